/* bp_counter_pkg.sv */
`default_nettype none

package bp_counter_pkg;

    // Two-bit choice counter; the upper half favors the RAS.
    typedef enum logic [1:0] {
        STRONG_BTB = 2'd0,
        WEAK_BTB   = 2'd1,
        WEAK_RAS   = 2'd2,
        STRONG_RAS = 2'd3
    } choice_cnt_e;

endpackage

`default_nettype wire

/* bp_kind_pkg.sv */
`default_nettype none

package bp_kind_pkg;

    // Branch kind, from the kind predictor and from execute.
    typedef enum logic [2:0] {
        NOT_JUMP      = 3'd0,
        DIRECT_JUMP   = 3'd1,
        JUMP          = 3'd2,
        CALL          = 3'd3,
        RET           = 3'd4,
        INDIRECT_JUMP = 3'd5,
        OTHER_JUMP    = 3'd6
    } branch_kind_e;

endpackage

`default_nettype wire

/* bpu_top.f */
+incdir+.
bp_kind_pkg.sv
bp_counter_pkg.sv
gh_hash.sv
btb.sv
ras.sv
cpht.sv
npc_predictor.sv
bpu_top.sv
tb_bpu_top.sv

/* bpu_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "npc_defines.svh"

module bpu_top (
    input  wire logic      [`ADDR_WIDTH-1:0] pc,
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    input  wire bp_kind_pkg::branch_kind_e   kind_pdc,
    input  wire logic                        taken_pdc,
    output logic           [`ADDR_WIDTH-1:0] npc_pdc,
    output logic                             choice_btb_ras,
    output logic           [`GH_WIDTH-1:0]   gh_index_pdc,
    input  wire bp_kind_pkg::branch_kind_e   kind_ex,
    input  wire logic                        taken_ex,
    input  wire logic      [`ADDR_WIDTH-1:0] npc_ex,
    input  wire logic      [`ADDR_WIDTH-1:0] pc_ex,
    input  wire logic                        choice_real,
    input  wire logic      [`GH_WIDTH-1:0]   gh_index_ex,
    input  wire logic                        mis_pdc
);

    logic [`ADDR_WIDTH-1:0] target_btb;
    logic [`ADDR_WIDTH-1:0] top_ras;
    logic                   choice_ras;
    logic                   btb_we;
    logic                   push_ex;
    logic                   pop_ex;
    logic                   pop_pdc;

    gh_hash gh_hash_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .pc           (pc),
        .kind_ex      (kind_ex),
        .taken_ex     (taken_ex),
        .gh_index_pdc (gh_index_pdc)
    );

    btb btb_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .index_pdc  (gh_index_pdc),
        .target_btb (target_btb),
        .we         (btb_we),
        .index_ex   (gh_index_ex),
        .target_ex  (npc_ex)
    );

    ras ras_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .push_ex (push_ex),
        .pop_ex  (pop_ex),
        .pc_ex   (pc_ex),
        .pop_pdc (pop_pdc),
        .mis_pdc (mis_pdc),
        .top_ras (top_ras)
    );

    // Trained only by resolved returns.
    cpht cpht_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .index_pdc   (gh_index_pdc),
        .choice_ras  (choice_ras),
        .we          (pop_ex),
        .index_ex    (gh_index_ex),
        .choice_real (choice_real)
    );

    npc_predictor npc_predictor_i (
        .pc             (pc),
        .kind_pdc       (kind_pdc),
        .taken_pdc      (taken_pdc),
        .kind_ex        (kind_ex),
        .target_btb     (target_btb),
        .top_ras        (top_ras),
        .choice_ras     (choice_ras),
        .btb_we         (btb_we),
        .push_ex        (push_ex),
        .pop_ex         (pop_ex),
        .pop_pdc        (pop_pdc),
        .npc_pdc        (npc_pdc),
        .choice_btb_ras (choice_btb_ras)
    );

endmodule

`default_nettype wire

/* btb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "npc_defines.svh"

module btb (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic [`GH_WIDTH-1:0]   index_pdc,
    output logic      [`ADDR_WIDTH-1:0] target_btb,
    input  wire logic                   we,
    input  wire logic [`GH_WIDTH-1:0]   index_ex,
    input  wire logic [`ADDR_WIDTH-1:0] target_ex
);

    logic [`ADDR_WIDTH-1:0] table_q [`TABLE_DEPTH];

    // Resolved targets from execute.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `TABLE_DEPTH; i++) begin
                table_q[i] <= '0;
            end
        end else if (we) begin
            table_q[index_ex] <= target_ex;
        end
    end

    // Read in the same cycle as the fetch address.
    assign target_btb = table_q[index_pdc];

    // The write index comes back through the pipeline and must be known.
    property p_index_known;
        @(posedge clk) disable iff (!rst_n)
            we |-> !$isunknown(index_ex);
    endproperty

    a_index_known: assert property (p_index_known)
        else $error("btb: write index has X bits");

endmodule

`default_nettype wire

/* cpht.sv */
`timescale 1ns/1ns
`default_nettype none

`include "npc_defines.svh"

module cpht (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic [`GH_WIDTH-1:0] index_pdc,
    output logic                      choice_ras,
    input  wire logic                 we,
    input  wire logic [`GH_WIDTH-1:0] index_ex,
    input  wire logic                 choice_real
);

    import bp_counter_pkg::*;

    choice_cnt_e cnt_q [`TABLE_DEPTH];

    // Saturating step toward the source that was right.
    function automatic choice_cnt_e cnt_next(choice_cnt_e cur, logic to_ras);
        choice_cnt_e nxt;
        case (cur)
            STRONG_BTB: nxt = to_ras ? WEAK_BTB   : STRONG_BTB;
            WEAK_BTB:   nxt = to_ras ? WEAK_RAS   : STRONG_BTB;
            WEAK_RAS:   nxt = to_ras ? STRONG_RAS : WEAK_BTB;
            default:    nxt = to_ras ? STRONG_RAS : WEAK_RAS;
        endcase
        return nxt;
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `TABLE_DEPTH; i++) begin
                cnt_q[i] <= WEAK_BTB;
            end
        end else if (we) begin
            cnt_q[index_ex] <= cnt_next(cnt_q[index_ex], choice_real);
        end
    end

    // Upper half of the counter picks the RAS.
    assign choice_ras = (cnt_q[index_pdc] == WEAK_RAS) || (cnt_q[index_pdc] == STRONG_RAS);

    property p_entry_known;
        @(posedge clk) disable iff (!rst_n)
            we |=> !$isunknown(cnt_q[$past(index_ex)]);
    endproperty

    a_entry_known: assert property (p_entry_known)
        else $error("cpht: updated counter holds X");

endmodule

`default_nettype wire

/* gh_hash.sv */
`timescale 1ns/1ns
`default_nettype none

`include "npc_defines.svh"

module gh_hash (
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    input  wire logic [`ADDR_WIDTH-1:0]    pc,
    input  wire bp_kind_pkg::branch_kind_e kind_ex,
    input  wire logic                      taken_ex,
    output logic      [`GH_WIDTH-1:0]      gh_index_pdc
);

    import bp_kind_pkg::*;

    logic [`GH_WIDTH-1:0] ghr_q;
    logic                 shift_en;

    // Only resolved branches of some kind move the history.
    assign shift_en = (kind_ex != NOT_JUMP);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ghr_q <= '0;
        end else if (shift_en) begin
            ghr_q <= {ghr_q[`GH_WIDTH-2:0], taken_ex};
        end
    end

    // Low PC bits folded with the history.
    assign gh_index_pdc = pc[`GH_WIDTH-1:0] ^ ghr_q;

endmodule

`default_nettype wire

/* npc_defines.svh */
`ifndef NPC_DEFINES_SVH
`define NPC_DEFINES_SVH

// Word address width of fetch and target addresses.
`define ADDR_WIDTH 30

// Global history length; also the width of every table index.
`define GH_WIDTH 8

// Number of return address stack entries, a power of two.
`define STACK_LEN 16

// Entries in the BTB and in the choice table.
`define TABLE_DEPTH (1 << `GH_WIDTH)

// Width of the return address stack pointers.
`define STACK_PTR_WIDTH $clog2(`STACK_LEN)

`endif

/* npc_predictor.sv */
`timescale 1ns/1ns
`default_nettype none

`include "npc_defines.svh"

module npc_predictor (
    input  wire logic      [`ADDR_WIDTH-1:0] pc,
    input  wire bp_kind_pkg::branch_kind_e   kind_pdc,
    input  wire logic                        taken_pdc,
    input  wire bp_kind_pkg::branch_kind_e   kind_ex,
    input  wire logic      [`ADDR_WIDTH-1:0] target_btb,
    input  wire logic      [`ADDR_WIDTH-1:0] top_ras,
    input  wire logic                        choice_ras,
    output logic                             btb_we,
    output logic                             push_ex,
    output logic                             pop_ex,
    output logic                             pop_pdc,
    output logic           [`ADDR_WIDTH-1:0] npc_pdc,
    output logic                             choice_btb_ras
);

    import bp_kind_pkg::*;

    localparam logic [`ADDR_WIDTH-1:0] STEP_ONE = 1;
    localparam logic [`ADDR_WIDTH-1:0] STEP_TWO = 2;

    logic [`ADDR_WIDTH-1:0] seq_pc;

    // Update strobes from the resolved branch.
    assign btb_we  = (kind_ex != NOT_JUMP);
    assign push_ex = (kind_ex == CALL);
    assign pop_ex  = (kind_ex == RET);

    // A predicted taken return pops the speculative stack.
    assign pop_pdc = taken_pdc && (kind_pdc == RET);

    // Odd word addresses step over the second half of a pair.
    assign seq_pc = pc[0] ? pc + STEP_TWO : pc + STEP_ONE;

    // 0 selects the BTB, 1 the RAS.
    assign choice_btb_ras = choice_ras;

    always_comb begin
        npc_pdc = seq_pc;
        if (taken_pdc) begin
            case (kind_pdc)
                DIRECT_JUMP,
                JUMP,
                CALL,
                INDIRECT_JUMP,
                OTHER_JUMP: npc_pdc = target_btb;
                RET:        npc_pdc = choice_ras ? top_ras : target_btb;
                default:    npc_pdc = seq_pc;
            endcase
        end
    end

    // No clock here; checked once the prediction inputs settle.
    always_comb begin
        if (taken_pdc) begin
            a_kind_legal: assert final (kind_pdc inside {NOT_JUMP, DIRECT_JUMP, JUMP, CALL,
                                                         RET, INDIRECT_JUMP, OTHER_JUMP})
                else $error("npc_predictor: illegal branch kind on a taken prediction");
        end
    end

endmodule

`default_nettype wire

/* ras.sv */
`timescale 1ns/1ns
`default_nettype none

`include "npc_defines.svh"

module ras (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   push_ex,
    input  wire logic                   pop_ex,
    input  wire logic [`ADDR_WIDTH-1:0] pc_ex,
    input  wire logic                   pop_pdc,
    input  wire logic                   mis_pdc,
    output logic      [`ADDR_WIDTH-1:0] top_ras
);

    localparam int PTR_W = `STACK_PTR_WIDTH;
    localparam logic [PTR_W-1:0]       PTR_ONE  = 1;
    localparam logic [`ADDR_WIDTH-1:0] ADDR_ONE = 1;

    logic [`ADDR_WIDTH-1:0] stack_q [`STACK_LEN];
    logic [PTR_W-1:0]       commit_ptr_q;
    logic [PTR_W-1:0]       commit_ptr_d;
    logic [PTR_W-1:0]       spec_ptr_q;
    logic                   resync;

    // Committed pointer moves only on resolved calls and returns.
    always_comb begin
        commit_ptr_d = commit_ptr_q;
        if (push_ex) begin
            commit_ptr_d = commit_ptr_q + PTR_ONE;
        end else if (pop_ex) begin
            commit_ptr_d = commit_ptr_q - PTR_ONE;
        end
    end

    // Speculative state is rebuilt from the committed one.
    assign resync = mis_pdc | push_ex | pop_ex;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            commit_ptr_q <= '0;
            spec_ptr_q   <= '0;
        end else begin
            commit_ptr_q <= commit_ptr_d;
            if (resync) begin
                spec_ptr_q <= commit_ptr_d;
            end else if (pop_pdc) begin
                spec_ptr_q <= spec_ptr_q - PTR_ONE;
            end
        end
    end

    // Return address of a call is the word after it.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `STACK_LEN; i++) begin
                stack_q[i] <= '0;
            end
        end else if (push_ex) begin
            stack_q[commit_ptr_q] <= pc_ex + ADDR_ONE;
        end
    end

    assign top_ras = stack_q[spec_ptr_q - PTR_ONE];

    // Execute resolves one branch per cycle, so the strobes are exclusive.
    property p_push_pop_excl;
        @(posedge clk) disable iff (!rst_n)
            !(push_ex && pop_ex);
    endproperty

    a_push_pop_excl: assert property (p_push_pop_excl)
        else $error("ras: push and pop in the same cycle");

endmodule

`default_nettype wire

/* tb_bpu_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "npc_defines.svh"

module tb_bpu_top;

    import bp_kind_pkg::*;
    import bp_counter_pkg::*;

    localparam int AW            = `ADDR_WIDTH;
    localparam int GH            = `GH_WIDTH;
    localparam int PW            = `STACK_PTR_WIDTH;
    localparam int CLK_PERIOD    = 100;
    localparam int RESET_CYCLES  = 10;
    localparam int SEQ_CYCLES    = 200;
    localparam int BTB_ROUNDS    = 100;
    localparam int RAS_CYCLES    = 300;
    localparam int MIS_ROUNDS    = 40;
    localparam int CHOICE_ROUNDS = 12;
    localparam int MIX_CYCLES    = 2000;
    localparam int TOTAL_CYCLES  = 2 * RESET_CYCLES + SEQ_CYCLES + 2 * BTB_ROUNDS + 2
                                   + RAS_CYCLES + 9 * MIS_ROUNDS + 8 * CHOICE_ROUNDS
                                   + MIX_CYCLES;
    localparam logic [GH-1:0] RAS_INDEX = 'h5a;
    localparam logic [AW-1:0] ONE       = 1;
    localparam logic [AW-1:0] TWO       = 2;
    localparam logic [PW-1:0] PTR_ONE   = 1;

    logic          clk;
    logic          rst_n;
    logic [AW-1:0] pc;
    branch_kind_e  kind_pdc;
    logic          taken_pdc;
    logic [AW-1:0] npc_pdc;
    logic          choice_btb_ras;
    logic [GH-1:0] gh_index_pdc;
    branch_kind_e  kind_ex;
    logic          taken_ex;
    logic [AW-1:0] npc_ex;
    logic [AW-1:0] pc_ex;
    logic          choice_real;
    logic [GH-1:0] gh_index_ex;
    logic          mis_pdc;

    logic [31:0] lfsr_q;
    int          check_count;
    int          error_count;
    int          test_count;
    int          test_checks;
    int          test_errors;

    // Reference state of the predictor.
    logic [AW-1:0] m_btb [`TABLE_DEPTH];
    logic [1:0]    m_cnt [`TABLE_DEPTH];
    logic [AW-1:0] m_stack [`STACK_LEN];
    logic [PW-1:0] m_commit;
    logic [PW-1:0] m_spec;
    logic [GH-1:0] m_ghr;

    bpu_top bpu_top_i (
        .pc             (pc),
        .clk            (clk),
        .rst_n          (rst_n),
        .kind_pdc       (kind_pdc),
        .taken_pdc      (taken_pdc),
        .npc_pdc        (npc_pdc),
        .choice_btb_ras (choice_btb_ras),
        .gh_index_pdc   (gh_index_pdc),
        .kind_ex        (kind_ex),
        .taken_ex       (taken_ex),
        .npc_ex         (npc_ex),
        .pc_ex          (pc_ex),
        .choice_real    (choice_real),
        .gh_index_ex    (gh_index_ex),
        .mis_pdc        (mis_pdc)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #((TOTAL_CYCLES + 200) * CLK_PERIOD);
        $display("Timeout: the tests did not finish within %0d cycles", TOTAL_CYCLES + 200);
        $display("Simulation finished: FAIL");
        $finish;
    end

    // Taps for x^32 + x^22 + x^2 + x + 1.
    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    function automatic branch_kind_e any_kind();
        logic [2:0] k;
        k = rand_bits(3);
        return (k == 3'd7) ? NOT_JUMP : branch_kind_e'(k);
    endfunction

    // Any kind that always takes the BTB target.
    function automatic branch_kind_e jump_kind();
        case (rand_bits(3) % 5)
            0:       return DIRECT_JUMP;
            1:       return JUMP;
            2:       return CALL;
            3:       return INDIRECT_JUMP;
            default: return OTHER_JUMP;
        endcase
    endfunction

    // Only eight PCs so that table entries and stack slots get reused.
    function automatic logic [AW-1:0] pool_pc();
        logic [AW-1:0] k;
        k = rand_bits(3);
        return 30'h0012_3400 + k * 30'h0000_04c3;
    endfunction

    function automatic logic [AW-1:0] hashed_pc(logic [GH-1:0] idx);
        logic [AW-1:0] p;
        p = pool_pc();
        return {p[AW-1:GH], idx ^ m_ghr};
    endfunction

    task automatic reset_model();
        for (int i = 0; i < `TABLE_DEPTH; i++) begin
            m_btb[i] = '0;
            m_cnt[i] = WEAK_BTB;
        end
        for (int i = 0; i < `STACK_LEN; i++) begin
            m_stack[i] = '0;
        end
        m_commit = '0;
        m_spec   = '0;
        m_ghr    = '0;
    endtask

    // Runs at the rising edge on the inputs the DUT samples there.
    task automatic step_model();
        logic [PW-1:0] commit_next;
        logic          spec_pop;
        if (!rst_n) begin
            reset_model();
        end else begin
            commit_next = m_commit;
            spec_pop    = taken_pdc && (kind_pdc == RET);
            if (kind_ex != NOT_JUMP) begin
                m_btb[gh_index_ex] = npc_ex;
                m_ghr = {m_ghr[GH-2:0], taken_ex};
            end
            if (kind_ex == CALL) begin
                m_stack[m_commit] = pc_ex + ONE;
                commit_next = m_commit + PTR_ONE;
            end else if (kind_ex == RET) begin
                commit_next = m_commit - PTR_ONE;
                if (choice_real && m_cnt[gh_index_ex] != STRONG_RAS) begin
                    m_cnt[gh_index_ex] = m_cnt[gh_index_ex] + 2'd1;
                end else if (!choice_real && m_cnt[gh_index_ex] != STRONG_BTB) begin
                    m_cnt[gh_index_ex] = m_cnt[gh_index_ex] - 2'd1;
                end
            end
            if (mis_pdc || kind_ex == CALL || kind_ex == RET) begin
                m_spec = commit_next;
            end else if (spec_pop) begin
                m_spec = m_spec - PTR_ONE;
            end
            m_commit = commit_next;
        end
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        test_checks++;
        if (actual !== expected) begin
            error_count++;
            test_errors++;
            $display("[FAIL] %s expected %0h actual %0h", what, expected, actual);
        end
    endtask

    task automatic begin_cycle();
        @(posedge clk);
        step_model();
    endtask

    task automatic end_cycle(input string name);
        logic [GH-1:0] idx;
        logic          exp_choice;
        logic [AW-1:0] exp_npc;
        logic [PW-1:0] top_ptr;
        @(negedge clk);
        idx        = pc[GH-1:0] ^ m_ghr;
        exp_choice = (m_cnt[idx] >= WEAK_RAS);
        top_ptr    = m_spec - PTR_ONE;
        exp_npc    = pc[0] ? pc + TWO : pc + ONE;
        if (taken_pdc && kind_pdc != NOT_JUMP && kind_pdc <= OTHER_JUMP) begin
            if (kind_pdc == RET && exp_choice) begin
                exp_npc = m_stack[top_ptr];
            end else begin
                exp_npc = m_btb[idx];
            end
        end
        check_value({name, " gh_index_pdc"}, idx, gh_index_pdc);
        check_value({name, " choice_btb_ras"}, exp_choice, choice_btb_ras);
        check_value({name, " npc_pdc"}, exp_npc, npc_pdc);
    endtask

    task automatic drive(input logic [AW-1:0] pc_v, input branch_kind_e kp, input logic tp,
                         input branch_kind_e ke, input logic te, input logic [AW-1:0] npc_v,
                         input logic [AW-1:0] pce_v, input logic cr, input logic [GH-1:0] gi,
                         input logic mis);
        pc          <= pc_v;
        kind_pdc    <= kp;
        taken_pdc   <= tp;
        kind_ex     <= ke;
        taken_ex    <= te;
        npc_ex      <= npc_v;
        pc_ex       <= pce_v;
        choice_real <= cr;
        gh_index_ex <= gi;
        mis_pdc     <= mis;
    endtask

    task automatic hold_reset();
        for (int i = 0; i < RESET_CYCLES - 1; i++) begin
            begin_cycle();
            rst_n <= 1'b0;
            drive(pool_pc(), NOT_JUMP, 1'b0, NOT_JUMP, 1'b0, 0, 0, 1'b0, 0, 1'b0);
        end
        begin_cycle();
        rst_n <= 1'b1;
        drive(pool_pc(), NOT_JUMP, 1'b0, NOT_JUMP, 1'b0, 0, 0, 1'b0, 0, 1'b0);
        end_cycle("reset");
    endtask

    task automatic finish_test(input string name);
        test_count++;
        $display("test %-12s %0d checks, %0d errors", name, test_checks, test_errors);
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic seq_path_test();
        logic tk;
        for (int i = 0; i < SEQ_CYCLES; i++) begin
            begin_cycle();
            tk = rand_bits(1);
            drive(rand_bits(AW), tk ? NOT_JUMP : any_kind(), tk, NOT_JUMP, 1'b0, 0, 0,
                  1'b0, 0, 1'b0);
            end_cycle("seq_path");
        end
    endtask

    task automatic btb_train_test();
        logic [GH-1:0] idx;
        for (int i = 0; i < BTB_ROUNDS; i++) begin
            begin_cycle();
            idx = rand_bits(GH);
            drive(pool_pc(), NOT_JUMP, 1'b0, jump_kind(), rand_bits(1), rand_bits(AW),
                  pool_pc(), 1'b1, idx, 1'b0);
            end_cycle("btb_train");
            begin_cycle();
            drive(hashed_pc(idx), jump_kind(), 1'b1, NOT_JUMP, 1'b0, 0, 0, 1'b0, 0, 1'b0);
            end_cycle("btb_train");
        end
    endtask

    task automatic ras_stack_test();
        logic [1:0]   sel;
        branch_kind_e k;
        // Two resolved returns push the probe entry to STRONG_RAS.
        for (int i = 0; i < 2; i++) begin
            begin_cycle();
            drive(pool_pc(), NOT_JUMP, 1'b0, RET, rand_bits(1), rand_bits(AW), pool_pc(),
                  1'b1, RAS_INDEX, 1'b0);
            end_cycle("ras_stack");
        end
        for (int i = 0; i < RAS_CYCLES; i++) begin
            begin_cycle();
            sel = rand_bits(2);
            k   = sel[1] ? CALL : (sel[0] ? RET : NOT_JUMP);
            drive(hashed_pc(RAS_INDEX), RET, rand_bits(1), k, rand_bits(1), rand_bits(AW),
                  pool_pc(), 1'b1, rand_bits(GH), 1'b0);
            end_cycle("ras_stack");
        end
    endtask

    task automatic mis_recover_test();
        int n;
        for (int r = 0; r < MIS_ROUNDS; r++) begin
            n = 1 + rand_bits(2);
            for (int i = 0; i < 3; i++) begin
                begin_cycle();
                drive(pool_pc(), NOT_JUMP, 1'b0, CALL, rand_bits(1), rand_bits(AW),
                      pool_pc(), 1'b0, rand_bits(GH), 1'b0);
                end_cycle("mis_recover");
            end
            for (int i = 0; i < n; i++) begin
                begin_cycle();
                drive(hashed_pc(RAS_INDEX), RET, 1'b1, NOT_JUMP, 1'b0, 0, 0, 1'b0, 0, 1'b0);
                end_cycle("mis_recover");
            end
            begin_cycle();
            drive(pool_pc(), NOT_JUMP, 1'b0, NOT_JUMP, 1'b0, 0, 0, 1'b0, 0, 1'b1);
            end_cycle("mis_recover");
            begin_cycle();
            drive(hashed_pc(RAS_INDEX), RET, 1'b1, NOT_JUMP, 1'b0, 0, 0, 1'b0, 0, 1'b0);
            end_cycle("mis_recover");
        end
    endtask

    task automatic choice_train_test();
        logic [GH-1:0] idx;
        hold_reset();
        for (int r = 0; r < CHOICE_ROUNDS; r++) begin
            idx = rand_bits(GH);
            // Four updates toward the RAS and then four toward the BTB.
            for (int i = 0; i < 8; i++) begin
                begin_cycle();
                drive(hashed_pc(idx), RET, 1'b1, RET, rand_bits(1), rand_bits(AW), pool_pc(),
                      i < 4, idx, 1'b0);
                end_cycle("choice_train");
            end
        end
    endtask

    task automatic mixed_traffic_test();
        for (int i = 0; i < MIX_CYCLES; i++) begin
            begin_cycle();
            drive(pool_pc(), any_kind(), rand_bits(1), any_kind(), rand_bits(1),
                  rand_bits(AW), pool_pc(), rand_bits(1), rand_bits(GH), rand_bits(3) == 0);
            end_cycle("mixed");
        end
    endtask

    initial begin
        lfsr_q      = 32'h61ca_ee8a;
        check_count = 0;
        error_count = 0;
        test_count  = 0;
        test_checks = 0;
        test_errors = 0;
        rst_n       = 1'b0;
        pc          = '0;
        kind_pdc    = NOT_JUMP;
        taken_pdc   = 1'b0;
        kind_ex     = NOT_JUMP;
        taken_ex    = 1'b0;
        npc_ex      = '0;
        pc_ex       = '0;
        choice_real = 1'b0;
        gh_index_ex = '0;
        mis_pdc     = 1'b0;
        hold_reset();
        seq_path_test();
        finish_test("seq_path");
        btb_train_test();
        finish_test("btb_train");
        ras_stack_test();
        finish_test("ras_stack");
        mis_recover_test();
        finish_test("mis_recover");
        choice_train_test();
        finish_test("choice_train");
        mixed_traffic_test();
        finish_test("mixed");
        $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
